//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rsa_operand_loader
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/burst_ram_model.sv
`timescale 1ns/1ns
`default_nettype none

module burst_ram_model import rsa_load_pkg::*; #(
    parameter logic [word_w-1:0] data_key  = '0,
    parameter logic [31:0]       rand_seed = 32'd0
) (
    input  wire                clk,
    input  wire                rstn,
    input  wire                rd_start,
    input  wire  [addr_w-1:0]  rd_addr,
    input  wire  [len_w-1:0]   rd_len,
    output logic               rd_data_valid,
    output logic [word_w-1:0]  rd_data,
    output logic               rd_last
);

    logic [addr_w-1:0] base;
    int                n;
    int                gap;

    // requests are picked up on the falling edge, data driven there too
    initial begin
        void'($urandom(rand_seed));
        rd_data_valid = 1'b0;
        rd_data       = '0;
        rd_last       = 1'b0;
        forever begin
            @(negedge clk);
            if (rstn && rd_start) begin
                base = rd_addr;
                n    = int'(rd_len) / bytes_per_word;
                for (int i = 0; i < n; i++) begin
                    gap = $urandom_range(3, 0);    // idle cycles before this word
                    @(negedge clk);
                    rd_data_valid = 1'b0;
                    rd_last       = 1'b0;
                    repeat (gap) @(negedge clk);
                    rd_data_valid = 1'b1;
                    rd_data       = (base + addr_w'(i)) ^ data_key;
                    rd_last       = (i == n - 1);
                end
                @(negedge clk);
                rd_data_valid = 1'b0;
                rd_last       = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
    output logic clk
);

    localparam int half_period = 4;    // 8 ns clock

    initial begin
        clk = 1'b0;
        forever begin
            #(half_period) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_rsa_operand_loader.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rsa_operand_loader import rsa_load_pkg::*; ();

    localparam logic [word_w-1:0] data_key  = 32'h5a3c_96e1;
    localparam logic [31:0]       rand_seed = 32'he4940971;
    // slots x longest operand x worst gap x period x loads, plus margin
    localparam int timeout_ns = num_slots * words_4096 * 4 * 8 * 6 + 20000;

    logic                 clk;
    logic                 rstn;
    logic                 start;
    logic [mode_w-1:0]    mode;
    logic                 rd_start;
    logic [addr_w-1:0]    rd_addr;
    logic [len_w-1:0]     rd_len;
    logic                 rd_data_valid;
    logic [word_w-1:0]    rd_data;
    logic                 rd_last;
    logic [num_slots-1:0] op_wr_en;
    logic [word_w-1:0]    op_din;
    logic [num_slots-1:0] fifo_full;
    logic                 load_done;

    int mismatch_cnt = 0;
    int fail_cnt     = 0;
    int load_cnt     = 0;

    // reference state
    logic                 start_q;
    logic                 clear_pending;
    logic                 armed;
    int                   cur_words;
    int                   req_cnt;
    int                   done_slots;
    int                   wr_cnt;
    logic                 start_rise;
    logic                 final_wr;
    logic [addr_w-1:0]    exp_addr;
    logic [len_w-1:0]     exp_len;
    logic [num_slots-1:0] exp_wr_en;
    logic [num_slots-1:0] exp_full;
    logic                 exp_done;
    logic [word_w-1:0]    exp_din;

    tb_clk_gen clk_gen_i (.clk(clk));

    rsa_operand_loader dut_i (
        .clk           (clk),
        .rstn          (rstn),
        .start         (start),
        .mode          (mode),
        .load_done     (load_done),
        .rd_start      (rd_start),
        .rd_addr       (rd_addr),
        .rd_len        (rd_len),
        .rd_data_valid (rd_data_valid),
        .rd_data       (rd_data),
        .rd_last       (rd_last),
        .op_wr_en      (op_wr_en),
        .op_din        (op_din),
        .fifo_full     (fifo_full)
    );

    burst_ram_model #(.data_key(data_key), .rand_seed(rand_seed)) ram_i (
        .clk           (clk),
        .rstn          (rstn),
        .rd_start      (rd_start),
        .rd_addr       (rd_addr),
        .rd_len        (rd_len),
        .rd_data_valid (rd_data_valid),
        .rd_data       (rd_data),
        .rd_last       (rd_last)
    );

    function automatic int operand_words(input logic [mode_w-1:0] m);
        case (m)
            mode_4096: return words_4096;
            mode_2048: return words_2048;
            mode_1024: return words_1024;
            default:   return words_512;
        endcase
    endfunction

    function automatic logic [num_slots-1:0] full_mask(input int n);
        return num_slots'((32'd1 << n) - 32'd1);    // low n slots full
    endfunction

    function automatic void note_mismatch(input string sig, input logic [31:0] got,
                                          input logic [31:0] exp);
        mismatch_cnt++;
        $display("Mismatch at %0t: %s got 0x%0h, expected 0x%0h", $time, sig, got, exp);
    endfunction

    function automatic void note_failure(input string what);
        fail_cnt++;
        $display("Error at %0t: %s", $time, what);
    endfunction

    // ================================================
    // reference model
    // ================================================
    assign start_rise = start & ~start_q;
    assign final_wr   = (|op_wr_en) && (wr_cnt == cur_words - 1);
    assign exp_addr   = addr_w'(req_cnt * cur_words);
    assign exp_len    = len_w'(cur_words * bytes_per_word);
    assign exp_wr_en  = num_slots'(1) << done_slots;
    assign exp_full   = final_wr ? full_mask(done_slots + 1) : full_mask(done_slots);
    assign exp_done   = (done_slots == num_slots) && !clear_pending;
    assign exp_din    = word_w'(done_slots * cur_words + wr_cnt) ^ data_key;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            start_q       <= 1'b0;
            clear_pending <= 1'b0;
            armed         <= 1'b0;
            cur_words     <= words_4096;
            req_cnt       <= 0;
            done_slots    <= 0;
            wr_cnt        <= 0;
        end else begin
            start_q       <= start;
            clear_pending <= start_rise;    // flags clear one cycle after the edge
            if (start_rise) begin
                armed     <= 1'b1;
                cur_words <= operand_words(mode);
            end
            if (clear_pending) begin
                req_cnt    <= 0;
                done_slots <= 0;
                wr_cnt     <= 0;
            end else begin
                if (rd_start) begin
                    req_cnt <= req_cnt + 1;
                end
                if (|op_wr_en) begin
                    if (final_wr) begin
                        wr_cnt     <= 0;
                        done_slots <= done_slots + 1;
                    end else begin
                        wr_cnt <= wr_cnt + 1;
                    end
                end
            end
        end
    end

    // ================================================
    // checks
    // ================================================
    a_reset_idle: assert property (@(posedge clk) disable iff (!rstn)
        !armed |-> ({rd_start, load_done, op_wr_en, fifo_full} == '0))
        else note_mismatch("rd_start,load_done,op_wr_en,fifo_full",
                           32'($sampled({rd_start, load_done, op_wr_en, fifo_full})), 32'd0);

    a_first_req_time: assert property (@(posedge clk) disable iff (!rstn)
        (rd_start && req_cnt == 0) |-> $past(start_rise, 2))
        else note_failure("first rd_start not one cycle after the start edge");

    a_first_req_seen: assert property (@(posedge clk) disable iff (!rstn)
        $past(start_rise, 2) |-> rd_start)
        else note_failure("no rd_start one cycle after the start edge");

    a_req_addr: assert property (@(posedge clk) disable iff (!rstn)
        rd_start |-> rd_addr == exp_addr)
        else note_mismatch("rd_addr", $sampled(rd_addr), $sampled(exp_addr));

    a_req_len: assert property (@(posedge clk) disable iff (!rstn)
        rd_start |-> rd_len == exp_len)
        else note_mismatch("rd_len", $sampled(rd_len), $sampled(exp_len));

    a_req_count: assert property (@(posedge clk) disable iff (!rstn)
        rd_start |-> req_cnt < num_slots)
        else note_failure("burst request issued after the fifth slot");

    // a new full bit (not the last) means the next request follows
    a_next_req: assert property (@(posedge clk) disable iff (!rstn)
        (fifo_full != $past(fifo_full) && fifo_full != '0 && fifo_full != '1) |=> rd_start)
        else note_failure("no burst request after a slot completed");

    a_wr_follows_valid: assert property (@(posedge clk) disable iff (!rstn)
        (|op_wr_en) == $past(rd_data_valid))
        else note_failure("op_wr_en does not follow rd_data_valid by one cycle");

    a_wr_slot: assert property (@(posedge clk) disable iff (!rstn)
        (|op_wr_en) |-> op_wr_en == exp_wr_en)
        else note_mismatch("op_wr_en", 32'($sampled(op_wr_en)), 32'($sampled(exp_wr_en)));

    a_din: assert property (@(posedge clk) disable iff (!rstn)
        (|op_wr_en) |-> op_din == exp_din)
        else note_mismatch("op_din", $sampled(op_din), $sampled(exp_din));

    a_full: assert property (@(posedge clk) disable iff (!rstn)
        fifo_full == exp_full)
        else note_mismatch("fifo_full", 32'($sampled(fifo_full)), 32'($sampled(exp_full)));

    a_done: assert property (@(posedge clk) disable iff (!rstn)
        load_done == exp_done)
        else note_mismatch("load_done", 32'($sampled(load_done)), 32'($sampled(exp_done)));

    // ================================================
    // stimulus
    // ================================================
    task automatic run_load(input logic [mode_w-1:0] m);
        @(negedge clk);
        mode  = m;
        start = 1'b1;
        repeat (3) @(negedge clk);    // old load_done gone by now
        while (!load_done) begin
            @(negedge clk);
        end
        load_cnt++;
        @(negedge clk);
        start = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    initial begin
        rstn  = 1'b0;
        start = 1'b0;
        mode  = mode_4096;
        repeat (4) @(negedge clk);
        rstn = 1'b1;
        repeat (3) @(negedge clk);
        run_load(mode_4096);
        run_load(mode_2048);
        run_load(mode_1024);
        run_load(mode_512);
        run_load(mode_512);    // re-arm
        repeat (4) @(negedge clk);
        $display("loads %0d, mismatches %0d, other errors %0d",
                 load_cnt, mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired before all loads finished");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/operand_burst_sched.sv
`timescale 1ns/1ns
`default_nettype none

module operand_burst_sched import rsa_load_pkg::*; (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   start,
    input  wire  [mode_w-1:0]     mode,
    input  wire                   slot_done,
    output logic                  load_start,
    output logic [mode_w-1:0]     mode_q,
    output logic [slot_idx_w-1:0] slot_idx,
    output logic                  rd_start,
    output logic [addr_w-1:0]     rd_addr,
    output logic [len_w-1:0]      rd_len,
    output logic                  load_done
);

    logic                  start_q;
    logic                  start_edge;
    logic                  start_ok;
    logic                  busy;
    logic                  last_slot;
    logic                  next_req;
    logic [slot_idx_w-1:0] req_idx;
    logic [cnt_w-1:0]      words;

    // ================================================
    // start edge and load control
    // ================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            start_q <= 1'b0;
        end else begin
            start_q <= start;
        end
    end

    assign start_edge = start & ~start_q;
    assign start_ok   = start_edge & ~busy;    // edges mid-load are dropped

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy       <= 1'b0;
            load_start <= 1'b0;
            load_done  <= 1'b0;
            mode_q     <= mode_4096;
        end else begin
            load_start <= start_ok;
            if (start_ok) begin
                busy      <= 1'b1;
                load_done <= 1'b0;
                mode_q    <= mode;             // held for the whole load
            end else if (slot_done && last_slot) begin
                busy      <= 1'b0;
                load_done <= 1'b1;
            end
        end
    end

    // ================================================
    // slot sequencing
    // ================================================
    assign last_slot = (slot_idx == slot_idx_w'(num_slots - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            slot_idx <= '0;
        end else if (start_ok) begin
            slot_idx <= '0;
        end else if (slot_done && !last_slot) begin
            slot_idx <= slot_idx + 1'b1;
        end
    end

    // ================================================
    // burst requests
    // ================================================
    // first request follows load_start, the rest follow slot_done
    assign next_req = load_start | (slot_done & ~last_slot);
    assign req_idx  = load_start ? '0 : slot_idx + 1'b1;
    assign words    = mode_words(mode_q);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_start <= 1'b0;
            rd_addr  <= '0;
            rd_len   <= '0;
        end else begin
            rd_start <= next_req;
            if (next_req) begin
                rd_addr <= addr_w'(req_idx) * addr_w'(words);          // word address
                rd_len  <= len_w'(words) * len_w'(bytes_per_word);     // bytes
            end
        end
    end

    // ================================================
    // checks
    // ================================================
    // a slot never completes on the cycle right after a request
    a_rd_start_pulse: assert property (@(posedge clk) disable iff (!rstn)
        rd_start |=> !rd_start)
        else $error("rd_start held high for two cycles");

    // host must wait for load_done before the next start
    a_no_start_busy: assert property (@(posedge clk) disable iff (!rstn)
        start_edge |-> !busy)
        else $error("start edge during a load, ignored");

endmodule

`default_nettype wire

//--- design/operand_word_steer.sv
`timescale 1ns/1ns
`default_nettype none

module operand_word_steer import rsa_load_pkg::*; (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   load_start,
    input  wire  [mode_w-1:0]     mode_q,
    input  wire  [slot_idx_w-1:0] slot_idx,
    input  wire                   rd_data_valid,
    input  wire  [word_w-1:0]     rd_data,
    input  wire                   rd_last,
    output logic [num_slots-1:0]  op_wr_en,
    output logic [word_w-1:0]     op_din,
    output logic [num_slots-1:0]  fifo_full,
    output logic                  slot_done
);

    logic [cnt_w-1:0]     word_cnt;
    logic [cnt_w-1:0]     last_cnt;
    logic                 last_word;
    logic [num_slots-1:0] slot_sel;

    assign last_cnt  = mode_words(mode_q) - 1'b1;
    assign last_word = rd_data_valid & (word_cnt == last_cnt);
    assign slot_sel  = num_slots'(1) << slot_idx;    // current fifo

    // ================================================
    // word counter
    // ================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            word_cnt <= '0;
        end else if (load_start) begin
            word_cnt <= '0;
        end else if (rd_data_valid) begin
            word_cnt <= last_word ? '0 : word_cnt + 1'b1;    // wraps per slot
        end
    end

    // ================================================
    // fifo write path
    // ================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            op_wr_en <= '0;
        end else begin
            op_wr_en <= rd_data_valid ? slot_sel : '0;
        end
    end

    // shared data bus, only one fifo written at a time
    always_ff @(posedge clk) begin
        if (rd_data_valid) begin
            op_din <= rd_data;
        end
    end

    // full flags and slot completion
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fifo_full <= '0;
            slot_done <= 1'b0;
        end else begin
            slot_done <= last_word;    // same cycle as the final write
            if (load_start) begin
                fifo_full <= '0;
            end else if (last_word) begin
                fifo_full <= fifo_full | slot_sel;
            end
        end
    end

    // ================================================
    // checks
    // ================================================
    // engine burst length must agree with the mode
    a_last_aligned: assert property (@(posedge clk) disable iff (!rstn)
        rd_data_valid |-> (rd_last == (word_cnt == last_cnt)))
        else $error("rd_last does not match counted final word");

    // slot index must stay inside the fifo range
    a_wr_en_onehot: assert property (@(posedge clk) disable iff (!rstn)
        rd_data_valid |=> $onehot(op_wr_en))
        else $error("op_wr_en not one-hot on a word write");

    // scheduler must not request data for a finished slot
    a_slot_not_full: assert property (@(posedge clk) disable iff (!rstn)
        rd_data_valid |-> ((fifo_full & slot_sel) == '0))
        else $error("word for a slot that is already full");

endmodule

`default_nettype wire

//--- design/rsa_load_pkg.sv
`default_nettype none

package rsa_load_pkg;

    // ================================================
    // widths
    // ================================================
    localparam int word_w     = 32;
    localparam int addr_w     = 32;    // word address
    localparam int len_w      = 32;    // burst length, bytes
    localparam int cnt_w      = 8;
    localparam int mode_w     = 2;

    localparam int num_slots  = 5;     // operand fifos
    localparam int slot_idx_w = 3;

    // ================================================
    // key size modes
    // ================================================
    localparam logic [mode_w-1:0] mode_4096 = 2'd0;
    localparam logic [mode_w-1:0] mode_2048 = 2'd1;
    localparam logic [mode_w-1:0] mode_1024 = 2'd2;
    localparam logic [mode_w-1:0] mode_512  = 2'd3;

    // operand length in words
    localparam int words_4096 = 128;
    localparam int words_2048 = 64;
    localparam int words_1024 = 32;
    localparam int words_512  = 16;

    localparam int bytes_per_word = 4;

    // words per operand for a mode code
    function automatic logic [cnt_w-1:0] mode_words(input logic [mode_w-1:0] m);
        logic [cnt_w-1:0] w;
        case (m)
            mode_4096: w = cnt_w'(words_4096);
            mode_2048: w = cnt_w'(words_2048);
            mode_1024: w = cnt_w'(words_1024);
            mode_512:  w = cnt_w'(words_512);
        endcase
        return w;
    endfunction

endpackage

`default_nettype wire

//--- design/rsa_operand_loader.sv
`timescale 1ns/1ns
`default_nettype none

module rsa_operand_loader import rsa_load_pkg::*; (
    input  wire                  clk,
    input  wire                  rstn,
    // host
    input  wire                  start,
    input  wire  [mode_w-1:0]    mode,
    output wire                  load_done,
    // burst read engine
    output wire                  rd_start,
    output wire  [addr_w-1:0]    rd_addr,
    output wire  [len_w-1:0]     rd_len,
    input  wire                  rd_data_valid,
    input  wire  [word_w-1:0]    rd_data,
    input  wire                  rd_last,
    // operand fifos
    output wire  [num_slots-1:0] op_wr_en,
    output wire  [word_w-1:0]    op_din,
    output wire  [num_slots-1:0] fifo_full
);

    logic                  load_start;
    logic [mode_w-1:0]     mode_q;
    logic [slot_idx_w-1:0] slot_idx;
    logic                  slot_done;

    // ================================================
    // request side
    // ================================================
    operand_burst_sched sched_i (
        .clk        (clk),
        .rstn       (rstn),
        .start      (start),
        .mode       (mode),
        .slot_done  (slot_done),
        .load_start (load_start),
        .mode_q     (mode_q),
        .slot_idx   (slot_idx),
        .rd_start   (rd_start),
        .rd_addr    (rd_addr),
        .rd_len     (rd_len),
        .load_done  (load_done)
    );

    // ================================================
    // return data side
    // ================================================
    operand_word_steer steer_i (
        .clk           (clk),
        .rstn          (rstn),
        .load_start    (load_start),
        .mode_q        (mode_q),
        .slot_idx      (slot_idx),
        .rd_data_valid (rd_data_valid),
        .rd_data       (rd_data),
        .rd_last       (rd_last),
        .op_wr_en      (op_wr_en),
        .op_din        (op_din),
        .fifo_full     (fifo_full),
        .slot_done     (slot_done)    // back to the scheduler
    );

endmodule

`default_nettype wire

//--- filelist.f
design/rsa_load_pkg.sv
design/operand_burst_sched.sv
design/operand_word_steer.sv
design/rsa_operand_loader.sv
bench/tb_clk_gen.sv
bench/burst_ram_model.sv
bench/tb_rsa_operand_loader.sv
